// ==== hw/capture_readout.sv ====
`timescale 1ns/10ps
`default_nettype none

module capture_readout import const_pack::*; #(
    parameter integer N_mem_tiles = N_tiles_default,
    localparam integer sys_addr = N_mem_addr + $clog2(N_mem_tiles)
) (
    input wire logic clk,
    input wire logic rstb,
    input wire logic rd_strobe,
    input wire logic [sys_addr-1:0] rd_addr,
    input wire logic busy,
    output logic [sys_addr-1:0] mem_addr,
    input wire mem_row_t mem_data,
    output logic rd_valid,
    output mem_row_t rd_data
);

    logic accept;
    logic req_q;
    logic req_qq;

    // The memory is owned by the capture FSM while busy
    assign accept = rd_strobe && !busy;

    always_ff @(posedge clk) begin
        if (!rstb) begin
            req_q <= 1'b0;
            req_qq <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            req_q <= accept;                            // Address is on mem_addr
            req_qq <= req_q;                            // SRAM word is on mem_data
            rd_valid <= req_qq;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr <= rd_addr;
        end
        if (req_qq) begin
            rd_data <= mem_data;
        end
    end

    // A strobe sampled during busy must never come back as a response
    a_no_busy_reply: assert property (
        @(posedge clk) disable iff (!rstb)
        (rd_strobe && busy) |-> ##3 !rd_valid
    );

endmodule

`default_nettype wire

// ==== hw/capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module capture_top import const_pack::*; #(
    localparam integer sys_addr = N_mem_addr + $clog2(N_tiles_default)
) (
    input wire logic clk,
    input wire logic rstb,
    input wire mem_row_t adc_row,
    input wire logic arm,
    input wire logic signed [Nadc-1:0] threshold,
    input wire logic rd_strobe,
    input wire logic [sys_addr-1:0] rd_addr,
    output logic capture_busy,
    output logic capture_done,
    output logic rd_valid,
    output mem_row_t rd_data
);

    mem_row_t row_q;
    mem_row_t mem_data;
    logic start_write;
    logic [sys_addr-1:0] mem_addr;

    trigger_detect trigger_detect_inst (
        .clk(clk),
        .rstb(rstb),
        .adc_row(adc_row),
        .arm(arm),
        .threshold(threshold),
        .row_q(row_q),
        .start_write(start_write)
    );

    oneshot_multimemory #(
        .N_mem_tiles(N_tiles_default)
    ) oneshot_multimemory_inst (
        .clk(clk),
        .rstb(rstb),
        .in_bytes(row_q),
        .in_start_write(start_write),
        .in_addr(mem_addr),
        .out_data(mem_data),
        .busy(capture_busy),
        .done(capture_done)
    );

    capture_readout #(
        .N_mem_tiles(N_tiles_default)
    ) capture_readout_inst (
        .clk(clk),
        .rstb(rstb),
        .rd_strobe(rd_strobe),
        .rd_addr(rd_addr),
        .busy(capture_busy),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .rd_valid(rd_valid),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== hw/const_pack.sv ====
package const_pack;

    localparam integer Nadc = 8;                        // Bits per ADC sample
    localparam integer N_mem_width = 4;                 // Samples per memory row
    localparam integer N_mem_addr = 4;                  // Row address bits inside one tile
    localparam integer N_tiles_default = 4;             // Tile count of the top level
    localparam integer N_row_bits = Nadc * N_mem_width;

    // Capture controller states
    localparam logic [1:0] st_wait = 2'd0;
    localparam logic [1:0] st_write = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

    // A memory row is seen as the SRAM data word or as the ADC sample lanes
    // Lanes hold two's complement samples with lane 0 in the low byte
    typedef union packed {
        logic [N_row_bits-1:0] flat;
        logic [N_mem_width-1:0][Nadc-1:0] lanes;
    } mem_row_t;

endpackage

// ==== hw/oneshot_multimemory.sv ====
`timescale 1ns/10ps
`default_nettype none

module oneshot_multimemory import const_pack::*; #(
    parameter integer N_mem_tiles = N_tiles_default,
    localparam integer tile_bits = $clog2(N_mem_tiles),
    localparam integer sys_addr = N_mem_addr + tile_bits
) (
    input wire logic clk,
    input wire logic rstb,
    input wire mem_row_t in_bytes,
    input wire logic in_start_write,
    input wire logic [sys_addr-1:0] in_addr,
    output mem_row_t out_data,
    output logic busy,
    output logic done
);

    localparam logic [sys_addr-1:0] max_addr = '1;

    logic [1:0] ctrl_state;
    logic web;
    logic [sys_addr-1:0] write_addr;

    logic [tile_bits-1:0] tile_mux;
    logic [tile_bits-1:0] rd_tile_q;
    logic [N_mem_addr-1:0] tile_addr;
    logic tile_en;
    logic [N_mem_tiles-1:0] tile_ceb;
    logic [N_row_bits-1:0] tile_q [N_mem_tiles];

    mem_row_t din_q;

    // The write FSM sweeps the whole address space once per trigger
    always_ff @(posedge clk) begin
        if (!rstb) begin
            ctrl_state <= st_wait;
            web <= 1'b1;
            write_addr <= '0;
        end else begin
            case (ctrl_state)
                st_write: begin
                    if (write_addr == max_addr) begin
                        web <= 1'b1;
                        ctrl_state <= st_done;
                    end else begin
                        write_addr <= write_addr + 1'b1;
                    end
                end
                st_done: begin
                    if (!in_start_write) begin
                        ctrl_state <= st_wait;          // Host must drop arm before a new shot
                    end
                end
                default: begin
                    write_addr <= '0;
                    if (in_start_write) begin
                        web <= 1'b0;
                        ctrl_state <= st_write;
                    end
                end
            endcase
        end
    end

    assign busy = (ctrl_state == st_write);
    assign done = (ctrl_state == st_done);

    // The input row is staged once more so that it lines up with the
    // registered write address and WEB
    always_ff @(posedge clk) begin
        din_q <= in_bytes;
        rd_tile_q <= tile_mux;                          // Follows the one cycle SRAM read
    end

    // Write address wins while WEB is low, otherwise the host address is used
    assign tile_addr = web ? in_addr[N_mem_addr-1:0] : write_addr[N_mem_addr-1:0];
    assign tile_mux = web ? in_addr[sys_addr-1:N_mem_addr] : write_addr[sys_addr-1:N_mem_addr];

    // Tiles are only enabled while writing or once a capture is complete
    assign tile_en = !web || (ctrl_state == st_done);

    genvar gi;
    generate
        for (gi = 0; gi < N_mem_tiles; gi = gi + 1) begin : g_tile
            assign tile_ceb[gi] = !(tile_en && (tile_mux == tile_bits'(gi)));

            sram #(
                .ADR_BITS(N_mem_addr),
                .DAT_BITS(N_row_bits)
            ) sram_inst (
                .clk(clk),
                .ceb(tile_ceb[gi]),
                .web(tile_ceb[gi] | web),
                .a(tile_addr),
                .d(din_q.flat),
                .q(tile_q[gi])
            );
        end
    endgenerate

    assign out_data.flat = tile_q[rd_tile_q];

    a_one_tile: assert property (
        @(posedge clk) disable iff (!rstb)
        $onehot0(~tile_ceb)
    );

    a_web_in_write: assert property (
        @(posedge clk) disable iff (!rstb)
        !web |-> (ctrl_state == st_write)
    );

endmodule

`default_nettype wire

// ==== hw/sram.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram #(
    parameter integer ADR_BITS = 4,
    parameter integer DAT_BITS = 32
) (
    input wire logic clk,
    input wire logic ceb,
    input wire logic web,
    input wire logic [ADR_BITS-1:0] a,
    input wire logic [DAT_BITS-1:0] d,
    output logic [DAT_BITS-1:0] q
);

    logic [DAT_BITS-1:0] mem [0:(1<<ADR_BITS)-1];

    always_ff @(posedge clk) begin
        if (!ceb && !web) begin
            mem[a] <= d;
        end
        if (!ceb) begin
            q <= mem[a];                                // A read during a write returns the old word
        end
    end

endmodule

`default_nettype wire

// ==== hw/trigger_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module trigger_detect import const_pack::*; (
    input wire logic clk,
    input wire logic rstb,
    input wire mem_row_t adc_row,
    input wire logic arm,
    input wire logic signed [Nadc-1:0] threshold,
    output mem_row_t row_q,
    output logic start_write
);

    logic hit;

    // Every row is registered, armed or not, so the capture path
    // always sees the same fixed latency from the ADC pins
    always_ff @(posedge clk) begin
        row_q <= adc_row;
    end

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < N_mem_width; i++) begin
            if ($signed(row_q.lanes[i]) > threshold) begin
                hit = 1'b1;                             // A lane equal to threshold does not fire
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstb) begin
            start_write <= 1'b0;
        end else if (!arm) begin
            start_write <= 1'b0;                        // Dropping arm is the only way out
        end else if (hit) begin
            start_write <= 1'b1;
        end
    end

    a_start_needs_arm: assert property (
        @(posedge clk) disable iff (!rstb)
        $rose(start_write) |-> $past(arm)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the capture memory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f src.f --top-module capture_tb \
    -Mdir obj_dir -o capture_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/capture_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== src.f ====
hw/const_pack.sv
hw/sram.sv
hw/trigger_detect.sv
hw/oneshot_multimemory.sv
hw/capture_readout.sv
hw/capture_top.sv
tb/capture_tb.sv

// ==== tb/capture_tb.sv ====
`timescale 1ns/10ps

module capture_tb import const_pack::*; ();

    localparam integer sys_addr = N_mem_addr + $clog2(N_tiles_default);
    localparam integer n_rows = 1 << sys_addr;
    localparam integer hist_depth = 4096;

    logic clk = 1'b0;
    logic rstb = 1'b0;
    mem_row_t adc_row = '0;
    logic arm = 1'b0;
    logic signed [Nadc-1:0] threshold = '0;
    logic rd_strobe = 1'b0;
    logic [sys_addr-1:0] rd_addr = '0;
    logic capture_busy;
    logic capture_done;
    logic rd_valid;
    mem_row_t rd_data;

    int cycle = 0;
    int force_at = -1;
    mem_row_t forced_row = '0;
    mem_row_t history [hist_depth];
    int trig_cycle = 0;

    mem_row_t exp_rows [$];
    int exp_due [$];
    string test_name = "reset";

    logic [31:0] lfsr = 32'h7c5d;
    int checks = 0;
    int errors = 0;

    always #2 clk = ~clk;

    capture_top capture_top_inst (
        .clk(clk),
        .rstb(rstb),
        .adc_row(adc_row),
        .arm(arm),
        .threshold(threshold),
        .rd_strobe(rd_strobe),
        .rd_addr(rd_addr),
        .capture_busy(capture_busy),
        .capture_done(capture_done),
        .rd_valid(rd_valid),
        .rd_data(rd_data)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return value;
    endfunction

    // Lanes sweep -64..63 and stay below the lowest threshold used while armed
    function automatic mem_row_t ramp_row(input int c);
        mem_row_t r;
        for (int i = 0; i < N_mem_width; i++) begin
            r.lanes[i] = Nadc'((((c * 3) + (i * 37)) & 127) - 64);
        end
        return r;
    endfunction

    // Stored row k is the row driven k+1 cycles after the triggering row
    function automatic mem_row_t expected_row(input int addr, input int trig);
        return history[(trig + addr + 1) % hist_depth];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR %s", what);
        end
    endtask

    task automatic print_counts();
        $display("checks %0d errors %0d", checks, errors);
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("ERROR timeout while waiting for %s", what);
        print_counts();
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // A new row is driven every cycle and recorded by cycle number
    always @(posedge clk) begin
        mem_row_t row;
        if (cycle == force_at) begin
            row = forced_row;
        end else begin
            row = ramp_row(cycle);
        end
        history[cycle % hist_depth] = row;
        adc_row <= row;
        cycle <= cycle + 1;
    end

    // Strobe driven at cycle c is taken at the next edge and shows up at c+4
    always @(negedge clk) begin
        mem_row_t want;
        int due;
        if (rstb === 1'b1 && rd_valid === 1'b1) begin
            check_true(exp_rows.size() != 0, "rd_valid pulse arrived with no read outstanding");
            if (exp_rows.size() != 0) begin
                want = exp_rows.pop_front();
                due = exp_due.pop_front();
                check_value(test_name, want.flat, rd_data.flat);
                check_value("read latency", due, cycle);
            end
        end
    end

    task automatic inject_row(input mem_row_t row, output int at);
        @(posedge clk);
        forced_row <= row;
        force_at <= cycle + 1;
        at = cycle + 1;
    endtask

    task automatic issue_read(input int addr);
        @(posedge clk);
        rd_strobe <= 1'b1;
        rd_addr <= sys_addr'(addr);
        exp_rows.push_back(expected_row(addr, trig_cycle));
        exp_due.push_back(cycle + 4);
    endtask

    task automatic finish_reads();
        int n;
        @(posedge clk);
        rd_strobe <= 1'b0;
        n = 0;
        while (exp_rows.size() != 0) begin
            if (n == 20) stop_on_timeout("outstanding read data");
            n++;
            @(posedge clk);
        end
    endtask

    task automatic run_capture();
        int thr;
        int lane;
        int at;
        int n;
        bit busy_seen;
        mem_row_t row;
        thr = 64 + random_bits(5);
        lane = random_bits(2);
        @(posedge clk);
        threshold <= Nadc'(thr);
        arm <= 1'b1;
        repeat (2 + random_bits(4)) @(posedge clk);

        test_name = "equal row";
        row = ramp_row(cycle);
        row.lanes[lane] = Nadc'(thr);                   // A lane at threshold must not fire
        inject_row(row, at);
        repeat (12) begin
            @(negedge clk);
            check_value("equal row busy", 32'd0, 32'(capture_busy));
        end

        test_name = "trigger";
        row = ramp_row(cycle);
        row.lanes[lane] = Nadc'(thr + 1 + random_bits(4));
        inject_row(row, trig_cycle);
        n = 0;
        @(negedge clk);
        while (capture_busy !== 1'b1) begin
            if (n == 20) stop_on_timeout("capture_busy after the trigger row");
            n++;
            @(negedge clk);
        end
        check_value("trigger delay", trig_cycle + 4, cycle);

        // Host strobes during the first part of the capture must be dropped
        test_name = "busy reads";
        n = 1;
        busy_seen = 1'b1;
        while (busy_seen) begin
            if (n == 200) stop_on_timeout("capture_busy to fall");
            @(posedge clk);
            rd_strobe <= (n < 40);
            rd_addr <= sys_addr'(random_bits(sys_addr));
            @(negedge clk);
            if (capture_busy === 1'b1) begin
                n++;
            end else begin
                busy_seen = 1'b0;
            end
        end
        check_value("busy length", n_rows, n);
        check_value("done after busy", 32'd1, 32'(capture_done));
    endtask

    task automatic read_all_rows();
        test_name = "full readout";
        for (int a = 0; a < n_rows; a++) begin
            issue_read(a);
        end
        finish_reads();
        test_name = "random reads";
        repeat (40) begin
            issue_read(random_bits(sys_addr));
        end
        finish_reads();
    endtask

    initial begin
        int n;
        int at;
        mem_row_t row;
        repeat (4) @(posedge clk);
        rstb <= 1'b1;
        @(negedge clk);
        check_value("reset busy", 32'd0, 32'(capture_busy));
        check_value("reset done", 32'd0, 32'(capture_done));
        check_value("reset rd_valid", 32'd0, 32'(rd_valid));

        // Rows far above threshold while arm is still low
        test_name = "idle";
        @(posedge clk);
        threshold <= Nadc'(10);
        row = ramp_row(cycle);
        row.lanes[0] = Nadc'(127);
        inject_row(row, at);
        repeat (16) begin
            @(negedge clk);
            check_value("idle busy", 32'd0, 32'(capture_busy));
            check_value("idle done", 32'd0, 32'(capture_done));
        end

        run_capture();
        read_all_rows();

        test_name = "re-arm";
        @(posedge clk);
        arm <= 1'b0;
        n = 0;
        @(negedge clk);
        while (capture_done !== 1'b0) begin
            if (n == 10) stop_on_timeout("capture_done to clear");
            n++;
            @(negedge clk);
        end
        check_value("busy after disarm", 32'd0, 32'(capture_busy));

        run_capture();
        read_all_rows();

        print_counts();
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
